//--- hw/sg1000_params.svh
`ifndef SG1000_PARAMS_SVH
`define SG1000_PARAMS_SVH

// cart address width, so the cart RAM holds 2**15 bytes.
`define SG_CART_AW 15

// console colour is 2 bits per channel, VGA colour is 6.
`define SG_COLOR_IN_W 2
`define SG_COLOR_OUT_W 6

`define SG_AUDIO_W 6

// cycles the console stays in reset after a download ends.
`define SG_RESET_HOLD 16

`endif

//--- hw/sg1000_pkg.sv
`default_nettype none

package sg1000_pkg;

	// scanline options as the OSD menu encodes them.
	// SCAN_RSVD used to select HQ2x and now passes video unchanged.
	typedef enum logic [1:0] {
		SCAN_NONE  = 2'd0,
		SCAN_RSVD  = 2'd1,
		SCAN_CRT25 = 2'd2,
		SCAN_CRT50 = 2'd3
	} scanline_mode_e;

	// cartridge loader states.
	// LD_SETTLE keeps the console in reset while the hold counter runs.
	typedef enum logic [1:0] {
		LD_IDLE    = 2'd0,
		LD_LOADING = 2'd1,
		LD_SETTLE  = 2'd2
	} loader_state_e;

endpackage

`default_nettype wire

//--- hw/rom_load_if.sv
`default_nettype none

`include "sg1000_params.svh"

// cartridge image stream from the configuration controller.
interface rom_load_if;
	logic                   download;
	logic                   wr;
	logic [`SG_CART_AW-1:0] addr;
	logic [7:0]             data;

	modport loader (
		input download, wr, addr, data
	);

	modport source (
		output download, wr, addr, data
	);
endinterface

`default_nettype wire

//--- hw/console_video_if.sv
`default_nettype none

`include "sg1000_params.svh"

// raw video from the console core, before blanking and expansion.
interface console_video_if;
	logic [`SG_COLOR_IN_W-1:0] r;
	logic [`SG_COLOR_IN_W-1:0] g;
	logic [`SG_COLOR_IN_W-1:0] b;
	logic                      hblank;
	logic                      vblank;
	logic                      hs;
	logic                      vs;

	modport console (
		output r, g, b, hblank, vblank, hs, vs
	);

	modport sink (
		input r, g, b, hblank, vblank, hs, vs
	);
endinterface

`default_nettype wire

//--- hw/cart_loader.sv
`default_nettype none

`include "sg1000_params.svh"

module cart_loader (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	rom_load_if.loader                  load,
	input  wire logic [`SG_CART_AW-1:0] console_addr,
	input  wire logic                   menu_reset,
	input  wire logic                   button_reset,
	output logic      [`SG_CART_AW-1:0] ram_addr,
	output logic                        ram_we,
	output logic      [7:0]             ram_wdata,
	output logic                        console_reset_n
);

	localparam int CW = $clog2(`SG_RESET_HOLD);

	// the edge that enters LD_SETTLE already counts as the first hold cycle.
	localparam logic [CW-1:0] HOLD_LOAD = CW'(`SG_RESET_HOLD - 1);

	sg1000_pkg::loader_state_e state;
	sg1000_pkg::loader_state_e state_d;
	logic [CW-1:0]             hold_cnt;

	// the loader owns the cart RAM port for the whole download.
	assign ram_addr  = load.download ? load.addr : console_addr;
	assign ram_we    = load.download & load.wr;
	assign ram_wdata = load.data;

	always_comb begin
		state_d = state;
		case (state)
			sg1000_pkg::LD_IDLE: begin
				if (load.download)
					state_d = sg1000_pkg::LD_LOADING;
			end
			sg1000_pkg::LD_LOADING: begin
				if (!load.download)
					state_d = sg1000_pkg::LD_SETTLE;
			end
			sg1000_pkg::LD_SETTLE: begin
				if (load.download)
					state_d = sg1000_pkg::LD_LOADING;
				else if (hold_cnt == CW'(1))
					state_d = sg1000_pkg::LD_IDLE;
			end
			default: state_d = sg1000_pkg::LD_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state           <= sg1000_pkg::LD_SETTLE;
			hold_cnt        <= HOLD_LOAD;
			console_reset_n <= 1'b0;
		end else begin
			state <= state_d;
			if (state != sg1000_pkg::LD_SETTLE)
				hold_cnt <= HOLD_LOAD;
			else
				hold_cnt <= hold_cnt - 1'b1;
			// release only once the loader is idle and nobody asks for reset.
			console_reset_n <= (state_d == sg1000_pkg::LD_IDLE) && !menu_reset && !button_reset;
		end
	end

endmodule

`default_nettype wire

//--- hw/cart_ram.sv
`default_nettype none

`include "sg1000_params.svh"

module cart_ram (
	input  wire logic                   clk_sys,
	input  wire logic [`SG_CART_AW-1:0] addr,
	input  wire logic                   we,
	input  wire logic [7:0]             wdata,
	output logic      [7:0]             rdata
);

	localparam int DEPTH = 1 << `SG_CART_AW;

	logic [7:0] mem [DEPTH];

	// write-first, so a write shows up on rdata in the next cycle.
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata     <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- hw/video_out.sv
`default_nettype none

`include "sg1000_params.svh"

module video_out (
	input  wire logic                        clk_sys,
	input  wire logic                        reset,
	console_video_if.sink                    vid,
	input  wire sg1000_pkg::scanline_mode_e  mode,
	output logic      [`SG_COLOR_OUT_W-1:0]  vga_r,
	output logic      [`SG_COLOR_OUT_W-1:0]  vga_g,
	output logic      [`SG_COLOR_OUT_W-1:0]  vga_b,
	output logic                             vga_hs,
	output logic                             vga_vs
);

	localparam int REP = `SG_COLOR_OUT_W / `SG_COLOR_IN_W;

	logic                       hs_q;
	logic                       odd_line;
	logic                       blank;
	logic [`SG_COLOR_OUT_W-1:0] r_d;
	logic [`SG_COLOR_OUT_W-1:0] g_d;
	logic [`SG_COLOR_OUT_W-1:0] b_d;

	// replicating the 2-bit value keeps full white at 63.
	function automatic logic [`SG_COLOR_OUT_W-1:0] expand(
		input logic [`SG_COLOR_IN_W-1:0] c,
		input logic                      blanked
	);
		if (blanked)
			return '0;
		return {REP{c}};
	endfunction

	function automatic logic [`SG_COLOR_OUT_W-1:0] dim(
		input logic [`SG_COLOR_OUT_W-1:0] c,
		input sg1000_pkg::scanline_mode_e m,
		input logic                       odd
	);
		if (!odd)
			return c;
		case (m)
			sg1000_pkg::SCAN_CRT50: return c >> 1;
			sg1000_pkg::SCAN_CRT25: return c - (c >> 2);
			default:                return c;
		endcase
	endfunction

	assign blank = vid.hblank | vid.vblank;

	assign r_d = dim(expand(vid.r, blank), mode, odd_line);
	assign g_d = dim(expand(vid.g, blank), mode, odd_line);
	assign b_d = dim(expand(vid.b, blank), mode, odd_line);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_q     <= 1'b0;
			odd_line <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
		end else begin
			hs_q <= vid.hs;
			// a new line starts on every rising edge of hsync.
			if (vid.hs && !hs_q)
				odd_line <= ~odd_line;
			vga_r  <= r_d;
			vga_g  <= g_d;
			vga_b  <= b_d;
			vga_hs <= vid.hs;
			vga_vs <= vid.vs;
		end
	end

endmodule

`default_nettype wire

//--- hw/audio_dac.sv
`default_nettype none

`include "sg1000_params.svh"

module audio_dac (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire logic [`SG_AUDIO_W-1:0] sample,
	output logic                        dac_out
);

	logic [`SG_AUDIO_W-1:0] acc;
	logic [`SG_AUDIO_W:0]   sum;

	// the carry fires sample times in every 2**SG_AUDIO_W cycles.
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[`SG_AUDIO_W-1:0];
			dac_out <= sum[`SG_AUDIO_W];
		end
	end

endmodule

`default_nettype wire

//--- hw/sg1000_board.sv
`default_nettype none

`include "sg1000_params.svh"

module sg1000_board (
	input  wire logic                        clk_sys,
	input  wire logic                        reset,
	input  wire logic                        download,
	input  wire logic                        dl_wr,
	input  wire logic [`SG_CART_AW-1:0]      dl_addr,
	input  wire logic [7:0]                  dl_data,
	input  wire logic [`SG_CART_AW-1:0]      cart_addr,
	input  wire logic [`SG_COLOR_IN_W-1:0]   r,
	input  wire logic [`SG_COLOR_IN_W-1:0]   g,
	input  wire logic [`SG_COLOR_IN_W-1:0]   b,
	input  wire logic                        hblank,
	input  wire logic                        vblank,
	input  wire logic                        hs,
	input  wire logic                        vs,
	input  wire logic [`SG_AUDIO_W-1:0]      audio,
	input  wire logic                        menu_reset,
	input  wire logic                        button_reset,
	input  wire sg1000_pkg::scanline_mode_e  scanline_mode,
	output logic      [7:0]                  cart_data,
	output logic                             console_reset_n,
	output logic      [`SG_COLOR_OUT_W-1:0]  vga_r,
	output logic      [`SG_COLOR_OUT_W-1:0]  vga_g,
	output logic      [`SG_COLOR_OUT_W-1:0]  vga_b,
	output logic                             vga_hs,
	output logic                             vga_vs,
	output logic                             audio_l,
	output logic                             audio_r,
	output logic                             led
);

	logic [`SG_CART_AW-1:0] ram_addr;
	logic                   ram_we;
	logic [7:0]             ram_wdata;

	rom_load_if      load_bus ();
	console_video_if vid_bus ();

	assign load_bus.download = download;
	assign load_bus.wr       = dl_wr;
	assign load_bus.addr     = dl_addr;
	assign load_bus.data     = dl_data;

	assign vid_bus.r      = r;
	assign vid_bus.g      = g;
	assign vid_bus.b      = b;
	assign vid_bus.hblank = hblank;
	assign vid_bus.vblank = vblank;
	assign vid_bus.hs     = hs;
	assign vid_bus.vs     = vs;

	// the LED is lit except while a cartridge is loading.
	assign led = ~download;

	cart_loader loader (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.load            (load_bus),
		.console_addr    (cart_addr),
		.menu_reset      (menu_reset),
		.button_reset    (button_reset),
		.ram_addr        (ram_addr),
		.ram_we          (ram_we),
		.ram_wdata       (ram_wdata),
		.console_reset_n (console_reset_n)
	);

	cart_ram cart (
		.clk_sys (clk_sys),
		.addr    (ram_addr),
		.we      (ram_we),
		.wdata   (ram_wdata),
		.rdata   (cart_data)
	);

	video_out video (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vid     (vid_bus),
		.mode    (scanline_mode),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	audio_dac dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (audio),
		.dac_out (audio_l)
	);

	// mono source, both channels carry the same stream.
	assign audio_r = audio_l;

endmodule

`default_nettype wire

//--- dv/sg1000_board_tb.sv
`default_nettype none

`include "sg1000_params.svh"

module sg1000_board_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum int {
		K_LOAD_READ,
		K_RESET_HOLD,
		K_VIDEO_PIXEL,
		K_SCANLINE,
		K_AUDIO_DENSITY
	} test_kind_e;

	localparam int N_BYTES = 64;
	localparam int WAIT_LIMIT = 200;

	logic                       clk_sys;
	logic                       reset;
	logic                       download;
	logic                       dl_wr;
	logic [`SG_CART_AW-1:0]     dl_addr;
	logic [7:0]                 dl_data;
	logic [`SG_CART_AW-1:0]     cart_addr;
	logic [`SG_COLOR_IN_W-1:0]  r;
	logic [`SG_COLOR_IN_W-1:0]  g;
	logic [`SG_COLOR_IN_W-1:0]  b;
	logic                       hblank;
	logic                       vblank;
	logic                       hs;
	logic                       vs;
	logic [`SG_AUDIO_W-1:0]     audio;
	logic                       menu_reset;
	logic                       button_reset;
	sg1000_pkg::scanline_mode_e scanline_mode;
	logic [7:0]                 cart_data;
	logic                       console_reset_n;
	logic [`SG_COLOR_OUT_W-1:0] vga_r;
	logic [`SG_COLOR_OUT_W-1:0] vga_g;
	logic [`SG_COLOR_OUT_W-1:0] vga_b;
	logic                       vga_hs;
	logic                       vga_vs;
	logic                       audio_l;
	logic                       audio_r;
	logic                       led;

	string       row_name[$];
	test_kind_e  row_kind[$];
	logic [31:0] row_a[$];
	logic [31:0] row_b[$];
	logic [31:0] row_c[$];
	logic [31:0] row_exp[$];

	logic [`SG_CART_AW-1:0] load_addr [N_BYTES];
	logic [7:0]             load_byte [N_BYTES];
	logic [31:0]            lfsr;
	logic                   line_odd;
	int                     test_errors;
	int                     total_errors;
	int                     tests_passed;
	int                     tests_failed;

	sg1000_board uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	task automatic random_byte(output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp)
		else begin
			$display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			test_errors++;
		end
	endtask

	// the line parity of the model flips on each rising edge of hsync.
	task automatic drive_hsync(input logic v);
		if (v && !hs)
			line_odd = !line_odd;
		hs = v;
	endtask

	task automatic add_row(input string name, input test_kind_e kind, input logic [31:0] a,
			input logic [31:0] fb, input logic [31:0] fc, input logic [31:0] exp);
		row_name.push_back(name);
		row_kind.push_back(kind);
		row_a.push_back(a);
		row_b.push_back(fb);
		row_c.push_back(fc);
		row_exp.push_back(exp);
	endtask

	task automatic add_pixel(input string name, input test_kind_e kind, input logic [1:0] pr,
			input logic [1:0] pg, input logic [1:0] pb, input logic [3:0] flags,
			input sg1000_pkg::scanline_mode_e mode, input logic [5:0] er,
			input logic [5:0] eg, input logic [5:0] eb);
		add_row(name, kind, {26'd0, pr, pg, pb}, {28'd0, flags}, {30'd0, mode},
			{14'd0, er, eg, eb});
	endtask

	task automatic set_reset_source(input logic [31:0] src, input logic v);
		case (src)
			32'd0:   download = v;
			32'd1:   menu_reset = v;
			default: button_reset = v;
		endcase
	endtask

	task automatic run_load_read(input int idx);
		int i;
		int gap;
		logic [7:0] v;
		logic [31:0] addr32;
		download = 1'b1;
		next_cycle();
		for (i = 0; i < int'(row_exp[idx]); i++) begin
			random_byte(v);
			addr32 = row_a[idx] + i * row_b[idx];
			load_addr[i] = addr32[`SG_CART_AW-1:0];
			load_byte[i] = v;
			dl_wr = 1'b1;
			dl_addr = load_addr[i];
			dl_data = v;
			next_cycle();
			check_value(row_name[idx], 32'd0, {31'd0, led});
			// the RAM reads write-first, so the new byte is already on cart_data.
			check_value(row_name[idx], {24'd0, v}, {24'd0, cart_data});
			dl_wr = 1'b0;
			for (gap = 0; gap < int'(row_c[idx]); gap++)
				next_cycle();
		end
		download = 1'b0;
		next_cycle();
		check_value(row_name[idx], 32'd1, {31'd0, led});
		for (i = 0; i < int'(row_exp[idx]); i++) begin
			cart_addr = load_addr[i];
			next_cycle();
			check_value(row_name[idx], {24'd0, load_byte[i]}, {24'd0, cart_data});
		end
	endtask

	task automatic run_reset_hold(input int idx);
		int i;
		int n;
		n = 0;
		while (!console_reset_n && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		assert (console_reset_n)
		else begin
			$display("%s: the console never left reset before the test", row_name[idx]);
			test_errors++;
		end
		set_reset_source(row_a[idx], 1'b1);
		for (i = 0; i < int'(row_b[idx]); i++) begin
			next_cycle();
			check_value(row_name[idx], 32'd0, {31'd0, console_reset_n});
			// only a download turns the LED off.
			check_value(row_name[idx], {31'd0, row_a[idx] != 32'd0}, {31'd0, led});
		end
		set_reset_source(row_a[idx], 1'b0);
		next_cycle();
		n = 1;
		while (!console_reset_n && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		assert (console_reset_n)
		else begin
			$display("%s: the console reset stayed low past the timeout", row_name[idx]);
			test_errors++;
		end
		check_value(row_name[idx], row_exp[idx], 32'(n));
	endtask

	task automatic run_pixel(input int idx, input logic scan);
		int n;
		scanline_mode = sg1000_pkg::scanline_mode_e'(row_c[idx][1:0]);
		if (scan) begin
			hblank = 1'b0;
			vblank = 1'b0;
			vs = 1'b0;
			drive_hsync(1'b0);
			next_cycle();
			n = 0;
			// one hsync pulse at most brings the line parity to the wanted value.
			while (line_odd != row_b[idx][0] && n < 4) begin
				drive_hsync(1'b1);
				next_cycle();
				drive_hsync(1'b0);
				next_cycle();
				n++;
			end
		end else begin
			hblank = row_b[idx][3];
			vblank = row_b[idx][2];
			drive_hsync(row_b[idx][1]);
			vs = row_b[idx][0];
		end
		r = row_a[idx][5:4];
		g = row_a[idx][3:2];
		b = row_a[idx][1:0];
		next_cycle();
		check_value(row_name[idx], row_exp[idx], {14'd0, vga_r, vga_g, vga_b});
		check_value(row_name[idx], {30'd0, hs, vs}, {30'd0, vga_hs, vga_vs});
	endtask

	task automatic run_audio(input int idx);
		int i;
		int count;
		audio = row_a[idx][`SG_AUDIO_W-1:0];
		for (i = 0; i < 64; i++)
			next_cycle();
		count = 0;
		for (i = 0; i < 64; i++) begin
			next_cycle();
			check_value(row_name[idx], {31'd0, audio_l}, {31'd0, audio_r});
			if (audio_l)
				count++;
		end
		check_value(row_name[idx], row_exp[idx], 32'(count));
	endtask

	initial begin
		int idx;
		reset = 1'b1;
		download = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cart_addr = '0;
		r = '0;
		g = '0;
		b = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hs = 1'b0;
		vs = 1'b0;
		audio = '0;
		menu_reset = 1'b0;
		button_reset = 1'b0;
		scanline_mode = sg1000_pkg::SCAN_NONE;
		lfsr = 32'hbbe9_812a;
		line_odd = 1'b0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;

		// load rows hold base address, stride, gap cycles and byte count.
		add_row("load_read_64", K_LOAD_READ, 32'h0100, 32'h0203, 32'd3, 32'd64);
		add_row("hold_after_load", K_RESET_HOLD, 32'd0, 32'd5, 32'd0, `SG_RESET_HOLD);
		add_row("menu_reset_pulse", K_RESET_HOLD, 32'd1, 32'd4, 32'd0, 32'd1);
		add_row("button_reset_pulse", K_RESET_HOLD, 32'd2, 32'd7, 32'd0, 32'd1);
		add_pixel("pix_white", K_VIDEO_PIXEL, 2'd3, 2'd3, 2'd3, 4'b0000,
			sg1000_pkg::SCAN_NONE, 6'd63, 6'd63, 6'd63);
		add_pixel("pix_mix", K_VIDEO_PIXEL, 2'd1, 2'd2, 2'd0, 4'b0010,
			sg1000_pkg::SCAN_NONE, 6'd21, 6'd42, 6'd0);
		add_pixel("pix_hblank", K_VIDEO_PIXEL, 2'd3, 2'd2, 2'd1, 4'b1011,
			sg1000_pkg::SCAN_NONE, 6'd0, 6'd0, 6'd0);
		add_pixel("pix_vblank", K_VIDEO_PIXEL, 2'd2, 2'd1, 2'd3, 4'b0101,
			sg1000_pkg::SCAN_NONE, 6'd0, 6'd0, 6'd0);
		add_pixel("pix_blue", K_VIDEO_PIXEL, 2'd0, 2'd1, 2'd3, 4'b0000,
			sg1000_pkg::SCAN_NONE, 6'd0, 6'd21, 6'd63);
		add_pixel("crt50_odd", K_SCANLINE, 2'd3, 2'd2, 2'd1, 4'd1,
			sg1000_pkg::SCAN_CRT50, 6'd31, 6'd21, 6'd10);
		add_pixel("crt50_even", K_SCANLINE, 2'd3, 2'd2, 2'd1, 4'd0,
			sg1000_pkg::SCAN_CRT50, 6'd63, 6'd42, 6'd21);
		add_pixel("crt25_odd", K_SCANLINE, 2'd3, 2'd2, 2'd1, 4'd1,
			sg1000_pkg::SCAN_CRT25, 6'd48, 6'd32, 6'd16);
		add_pixel("crt25_even", K_SCANLINE, 2'd1, 2'd3, 2'd0, 4'd0,
			sg1000_pkg::SCAN_CRT25, 6'd21, 6'd63, 6'd0);
		add_pixel("rsvd_odd", K_SCANLINE, 2'd3, 2'd3, 2'd3, 4'd1,
			sg1000_pkg::SCAN_RSVD, 6'd63, 6'd63, 6'd63);
		add_row("audio_0", K_AUDIO_DENSITY, 32'd0, 32'd0, 32'd0, 32'd0);
		add_row("audio_1", K_AUDIO_DENSITY, 32'd1, 32'd0, 32'd0, 32'd1);
		add_row("audio_21", K_AUDIO_DENSITY, 32'd21, 32'd0, 32'd0, 32'd21);
		add_row("audio_32", K_AUDIO_DENSITY, 32'd32, 32'd0, 32'd0, 32'd32);
		add_row("audio_63", K_AUDIO_DENSITY, 32'd63, 32'd0, 32'd0, 32'd63);

		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		for (idx = 0; idx < row_name.size(); idx++) begin
			test_errors = 0;
			case (row_kind[idx])
				K_LOAD_READ:   run_load_read(idx);
				K_RESET_HOLD:  run_reset_hold(idx);
				K_VIDEO_PIXEL: run_pixel(idx, 1'b0);
				K_SCANLINE:    run_pixel(idx, 1'b1);
				default:       run_audio(idx);
			endcase
			if (test_errors == 0) begin
				$display("done %s: ok", row_name[idx]);
				tests_passed++;
			end else begin
				$display("done %s: %0d errors", row_name[idx], test_errors);
				tests_failed++;
			end
			total_errors += test_errors;
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			row_name.size(), tests_passed, tests_failed, total_errors);
		if (tests_failed == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sg1000_board.f
+incdir+hw
hw/sg1000_pkg.sv
hw/rom_load_if.sv
hw/console_video_if.sv
hw/cart_loader.sv
hw/cart_ram.sv
hw/video_out.sv
hw/audio_dac.sv
hw/sg1000_board.sv
dv/sg1000_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f sg1000_board.f --top-module sg1000_board_tb -o sim_sg1000
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_sg1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1
